//--- rtl/noc_shell_pkg.sv
// Shared definitions for the single-port NoC shell
// Stream beat struct and CHDR header field types
// Packet type encoding from the header type bits
// Settings addresses, readback selectors and shell constants

`default_nettype none

package noc_shell_pkg;

   ////////////////////////////////////////
   // Stream beat and header fields
   ////////////////////////////////////////

   // One 64-bit stream beat with its last marker
   typedef struct packed {
      logic        tlast;
      logic [63:0] tdata;
   } chdr_beat_t;

   // Built from header bits {63, 62, 60}
   typedef enum logic [2:0] {
      DATA     = 3'd0,
      DATA_EOB = 3'd1,
      FC_RESP  = 3'd2,
      FC_ACK   = 3'd3,
      CMD      = 3'd4,
      CMD_EOB  = 3'd5,
      RESP     = 3'd6,
      RESP_ERR = 3'd7
   } pkt_type_e;

   typedef logic [11:0] seqnum_t;
   typedef logic [15:0] pkt_len_t;
   typedef logic [15:0] sid_t;
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] rb_data_t;
   typedef logic [2:0]  rb_sel_t;

   ////////////////////////////////////////
   // Settings and readback map
   ////////////////////////////////////////

   localparam set_addr_t SR_RB_ADDR      = 8'd124;
   localparam set_addr_t SR_SRC_SID      = 8'd128;
   localparam set_addr_t SR_NEXT_DST_SID = 8'd129;

   localparam rb_sel_t RB_NOC_ID          = 3'd0;
   localparam rb_sel_t RB_BLOCK_PORT_SIDS = 3'd4;
   localparam rb_sel_t RB_USER_RB_DATA    = 3'd5;
   localparam rb_sel_t RB_COMPAT_NUM      = 3'd6;

   localparam logic [31:0] COMPAT_MAJOR = 32'd4;
   localparam logic [31:0] COMPAT_MINOR = 32'd0;

   // Answer for an unknown readback selector
   localparam rb_data_t RB_BAD_ADDR = 64'h0BAD_C0DE_0BAD_C0DE;

   // Header plus one readback beat, in bytes
   localparam pkt_len_t RESP_LEN = 16'd16;

endpackage

`default_nettype wire

//--- rtl/pkt_type_router.sv
// Input packet router
// Decodes the packet type from the first beat and steers the whole packet
// to the stream sink, the command processor, or a discard sink

`default_nettype none

module pkt_type_router (
   input  wire                             clk,
   input  wire                             reset,
   input  wire noc_shell_pkg::chdr_beat_t  i_in_beat,
   input  wire                             i_in_valid,
   output logic                            o_in_ready,
   output noc_shell_pkg::chdr_beat_t       o_data_beat,
   output logic                            o_data_valid,
   input  wire                             i_data_ready,
   output noc_shell_pkg::chdr_beat_t       o_cmd_beat,
   output logic                            o_cmd_valid,
   input  wire                             i_cmd_ready
);

   typedef enum logic [1:0] {
      DEST_DATA,
      DEST_CMD,
      DEST_DROP
   } dest_e;

   noc_shell_pkg::pkt_type_e hdr_type;
   dest_e                    hdr_dest;
   dest_e                    held_dest;
   dest_e                    cur_dest;
   logic                     first_beat;

   assign hdr_type = noc_shell_pkg::pkt_type_e'({i_in_beat.tdata[63:62], i_in_beat.tdata[60]});

   // FC ACK stays in line with data while flow-control and response packets are dropped
   always_comb begin
      case (hdr_type)
         noc_shell_pkg::DATA,
         noc_shell_pkg::DATA_EOB,
         noc_shell_pkg::FC_ACK:   hdr_dest = DEST_DATA;
         noc_shell_pkg::CMD,
         noc_shell_pkg::CMD_EOB:  hdr_dest = DEST_CMD;
         default:                 hdr_dest = DEST_DROP;
      endcase
   end

   // Header decides and later beats follow the held choice
   assign cur_dest = first_beat ? hdr_dest : held_dest;

   assign o_data_beat  = i_in_beat;
   assign o_cmd_beat   = i_in_beat;
   assign o_data_valid = i_in_valid && (cur_dest == DEST_DATA);
   assign o_cmd_valid  = i_in_valid && (cur_dest == DEST_CMD);

   always_comb begin
      case (cur_dest)
         DEST_DATA: o_in_ready = i_data_ready;
         DEST_CMD:  o_in_ready = i_cmd_ready;
         default:   o_in_ready = 1'b1;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         first_beat <= 1'b1;
         held_dest  <= DEST_DROP;
      end else if (i_in_valid && o_in_ready) begin
         first_beat <= i_in_beat.tlast;
         held_dest  <= cur_dest;
      end
   end

endmodule

`default_nettype wire

//--- rtl/cmd_pkt_proc.sv
// Command packet processor
// Turns each command packet into one settings-bus write,
// waits for the readback word and answers with a two-beat response
// Only one command is in flight at a time

`default_nettype none

module cmd_pkt_proc (
   input  wire                             clk,
   input  wire                             reset,
   input  wire noc_shell_pkg::chdr_beat_t  i_cmd_beat,
   input  wire                             i_cmd_valid,
   output logic                            o_cmd_ready,
   output logic                            o_set_stb,
   output noc_shell_pkg::set_addr_t        o_set_addr,
   output noc_shell_pkg::set_data_t        o_set_data,
   input  wire                             i_rb_stb,
   input  wire noc_shell_pkg::rb_data_t    i_rb_data,
   output noc_shell_pkg::chdr_beat_t       o_resp_beat,
   output logic                            o_resp_valid,
   input  wire                             i_resp_ready
);

   typedef enum logic [2:0] {
      HEADER,
      PAYLOAD,
      DRAIN,
      WAIT_RB,
      RESP_HDR,
      RESP_DATA
   } state_e;

   // Header type bits of a response packet
   localparam logic [2:0] RESP_TYPE = noc_shell_pkg::RESP;

   state_e                  state;
   logic                    cmd_xfer;
   logic                    rb_take;
   noc_shell_pkg::seqnum_t  seqnum;
   noc_shell_pkg::sid_t     cmd_src_sid;
   noc_shell_pkg::sid_t     cmd_dst_sid;
   noc_shell_pkg::rb_data_t rb_word;
   logic [63:0]             resp_hdr;

   assign o_cmd_ready = (state == HEADER) || (state == PAYLOAD) || (state == DRAIN);
   assign cmd_xfer    = i_cmd_valid && o_cmd_ready;

   // Readback is stale while the strobe is still out
   assign rb_take = (state == WAIT_RB) && i_rb_stb && !o_set_stb;

   ////////////////////////////////////////
   // Control FSM
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= HEADER;
         o_set_stb <= 1'b0;
      end else begin
         o_set_stb <= 1'b0;
         case (state)
            HEADER: begin
               // A header-only command carries no write and is dropped
               if (cmd_xfer && !i_cmd_beat.tlast) begin
                  state <= PAYLOAD;
               end
            end
            PAYLOAD: begin
               if (cmd_xfer) begin
                  o_set_stb <= 1'b1;
                  state     <= i_cmd_beat.tlast ? WAIT_RB : DRAIN;
               end
            end
            DRAIN: begin
               if (cmd_xfer && i_cmd_beat.tlast) begin
                  state <= WAIT_RB;
               end
            end
            WAIT_RB: begin
               if (rb_take) begin
                  state <= RESP_HDR;
               end
            end
            RESP_HDR: begin
               if (i_resp_ready) begin
                  state <= RESP_DATA;
               end
            end
            RESP_DATA: begin
               if (i_resp_ready) begin
                  state <= HEADER;
               end
            end
            default: state <= HEADER;
         endcase
      end
   end

   ////////////////////////////////////////
   // Captured fields
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if ((state == HEADER) && cmd_xfer) begin
         seqnum      <= i_cmd_beat.tdata[59:48];
         cmd_src_sid <= i_cmd_beat.tdata[31:16];
         cmd_dst_sid <= i_cmd_beat.tdata[15:0];
      end
      if ((state == PAYLOAD) && cmd_xfer) begin
         o_set_addr <= i_cmd_beat.tdata[39:32];
         o_set_data <= i_cmd_beat.tdata[31:0];
      end
      if (rb_take) begin
         rb_word <= i_rb_data;
      end
   end

   // Response goes back to the sender, so the SIDs swap
   assign resp_hdr  = {RESP_TYPE[2:1], 1'b0, RESP_TYPE[0], seqnum,
                       noc_shell_pkg::RESP_LEN, cmd_dst_sid, cmd_src_sid};

   assign o_resp_valid = (state == RESP_HDR) || (state == RESP_DATA);

   always_comb begin
      o_resp_beat.tlast = (state == RESP_DATA);
      o_resp_beat.tdata = (state == RESP_DATA) ? rb_word : resp_hdr;
   end

endmodule

`default_nettype wire

//--- rtl/shell_regs.sv
// Shell settings registers and readback mux
// Holds the block SID, next destination SID and readback selector
// Registers the selected readback word and its strobe every cycle

`default_nettype none

module shell_regs #(
   parameter noc_shell_pkg::rb_data_t NOC_ID = 64'hDEAD_BEEF_0123_4567
) (
   input  wire                           clk,
   input  wire                           reset,
   input  wire                           i_set_stb,
   input  wire noc_shell_pkg::set_addr_t i_set_addr,
   input  wire noc_shell_pkg::set_data_t i_set_data,
   input  wire                           i_rb_stb,
   input  wire noc_shell_pkg::rb_data_t  i_rb_data,
   output logic                          o_rb_stb,
   output noc_shell_pkg::rb_data_t       o_rb_data,
   output noc_shell_pkg::sid_t           o_src_sid,
   output noc_shell_pkg::sid_t           o_next_dst_sid
);

   noc_shell_pkg::rb_sel_t rb_sel;
   logic                   sel_ready;

   ////////////////////////////////////////
   // Settings registers
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         o_src_sid      <= '0;
         o_next_dst_sid <= '0;
         rb_sel         <= noc_shell_pkg::RB_NOC_ID;
      end else if (i_set_stb) begin
         case (i_set_addr)
            noc_shell_pkg::SR_SRC_SID:      o_src_sid      <= i_set_data[15:0];
            noc_shell_pkg::SR_NEXT_DST_SID: o_next_dst_sid <= i_set_data[15:0];
            noc_shell_pkg::SR_RB_ADDR:      rb_sel         <= i_set_data[2:0];
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////
   // Readback mux
   ////////////////////////////////////////

   // Only the user source can be slow to answer
   assign sel_ready = (rb_sel != noc_shell_pkg::RB_USER_RB_DATA) || i_rb_stb;

   // Dropped on any write so a response never carries the old selection
   always_ff @(posedge clk) begin
      if (reset) begin
         o_rb_stb <= 1'b0;
      end else begin
         o_rb_stb <= sel_ready && !i_set_stb;
      end
   end

   always_ff @(posedge clk) begin
      case (rb_sel)
         noc_shell_pkg::RB_NOC_ID:
            o_rb_data <= NOC_ID;
         noc_shell_pkg::RB_BLOCK_PORT_SIDS:
            o_rb_data <= {o_src_sid, o_next_dst_sid, 32'd0};
         noc_shell_pkg::RB_USER_RB_DATA:
            o_rb_data <= i_rb_data;
         noc_shell_pkg::RB_COMPAT_NUM:
            o_rb_data <= {noc_shell_pkg::COMPAT_MAJOR, noc_shell_pkg::COMPAT_MINOR};
         default:
            o_rb_data <= noc_shell_pkg::RB_BAD_ADDR;
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/output_arbiter.sv
// Output merge of the stream source and command responses
// Round-robin between the two inputs, locked for a whole packet
// so packets never interleave on the output

`default_nettype none

module output_arbiter (
   input  wire                             clk,
   input  wire                             reset,
   input  wire noc_shell_pkg::chdr_beat_t  i_src_beat,
   input  wire                             i_src_valid,
   output logic                            o_src_ready,
   input  wire noc_shell_pkg::chdr_beat_t  i_resp_beat,
   input  wire                             i_resp_valid,
   output logic                            o_resp_ready,
   output noc_shell_pkg::chdr_beat_t       o_out_beat,
   output logic                            o_out_valid,
   input  wire                             i_out_ready
);

   logic locked;
   logic locked_resp;
   logic last_resp;
   logic sel_resp;

   // A high grant select picks the response input
   always_comb begin
      if (locked) begin
         sel_resp = locked_resp;
      end else if (i_src_valid && i_resp_valid) begin
         sel_resp = !last_resp;
      end else begin
         sel_resp = i_resp_valid;
      end
   end

   assign o_out_beat   = sel_resp ? i_resp_beat : i_src_beat;
   assign o_out_valid  = sel_resp ? i_resp_valid : i_src_valid;
   assign o_src_ready  = !sel_resp && i_out_ready;
   assign o_resp_ready = sel_resp && i_out_ready;

   ////////////////////////////////////////
   // Lock and round-robin state
   ////////////////////////////////////////

   // Lock as soon as a first beat shows, so a stalled beat stays put
   always_ff @(posedge clk) begin
      if (reset) begin
         locked      <= 1'b0;
         locked_resp <= 1'b0;
         last_resp   <= 1'b1;
      end else if (o_out_valid) begin
         if (!locked) begin
            last_resp <= sel_resp;
         end
         if (i_out_ready && o_out_beat.tlast) begin
            locked <= 1'b0;
         end else begin
            locked      <= 1'b1;
            locked_resp <= sel_resp;
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/noc_shell_top.sv
// Single-port NoC shell top level
// Packet type router, command processor, shell registers
// and the output arbiter that merges responses with the stream source

`default_nettype none

module noc_shell_top #(
   parameter noc_shell_pkg::rb_data_t NOC_ID = 64'hDEAD_BEEF_0123_4567
) (
   input  wire                             clk,
   input  wire                             reset,
   // Input from the crossbar
   input  wire noc_shell_pkg::chdr_beat_t  i_in_beat,
   input  wire                             i_in_valid,
   output logic                            o_in_ready,
   // Output to the crossbar
   output noc_shell_pkg::chdr_beat_t       o_out_beat,
   output logic                            o_out_valid,
   input  wire                             i_out_ready,
   // Stream sink
   output noc_shell_pkg::chdr_beat_t       o_sink_beat,
   output logic                            o_sink_valid,
   input  wire                             i_sink_ready,
   // Stream source
   input  wire noc_shell_pkg::chdr_beat_t  i_src_beat,
   input  wire                             i_src_valid,
   output logic                            o_src_ready,
   // Settings bus and user readback
   output logic                            o_set_stb,
   output noc_shell_pkg::set_addr_t        o_set_addr,
   output noc_shell_pkg::set_data_t        o_set_data,
   input  wire                             i_rb_stb,
   input  wire noc_shell_pkg::rb_data_t    i_rb_data,
   // Stream IDs
   output noc_shell_pkg::sid_t             o_src_sid,
   output noc_shell_pkg::sid_t             o_next_dst_sid
);

   noc_shell_pkg::chdr_beat_t cmd_beat;
   logic                      cmd_valid;
   logic                      cmd_ready;
   noc_shell_pkg::chdr_beat_t resp_beat;
   logic                      resp_valid;
   logic                      resp_ready;
   logic                      rb_stb;
   noc_shell_pkg::rb_data_t   rb_data;

   pkt_type_router u_router (
      .clk          (clk),
      .reset        (reset),
      .i_in_beat    (i_in_beat),
      .i_in_valid   (i_in_valid),
      .o_in_ready   (o_in_ready),
      .o_data_beat  (o_sink_beat),
      .o_data_valid (o_sink_valid),
      .i_data_ready (i_sink_ready),
      .o_cmd_beat   (cmd_beat),
      .o_cmd_valid  (cmd_valid),
      .i_cmd_ready  (cmd_ready)
   );

   cmd_pkt_proc u_cmd_proc (
      .clk          (clk),
      .reset        (reset),
      .i_cmd_beat   (cmd_beat),
      .i_cmd_valid  (cmd_valid),
      .o_cmd_ready  (cmd_ready),
      .o_set_stb    (o_set_stb),
      .o_set_addr   (o_set_addr),
      .o_set_data   (o_set_data),
      .i_rb_stb     (rb_stb),
      .i_rb_data    (rb_data),
      .o_resp_beat  (resp_beat),
      .o_resp_valid (resp_valid),
      .i_resp_ready (resp_ready)
   );

   shell_regs #(
      .NOC_ID (NOC_ID)
   ) u_regs (
      .clk            (clk),
      .reset          (reset),
      .i_set_stb      (o_set_stb),
      .i_set_addr     (o_set_addr),
      .i_set_data     (o_set_data),
      .i_rb_stb       (i_rb_stb),
      .i_rb_data      (i_rb_data),
      .o_rb_stb       (rb_stb),
      .o_rb_data      (rb_data),
      .o_src_sid      (o_src_sid),
      .o_next_dst_sid (o_next_dst_sid)
   );

   output_arbiter u_out_arb (
      .clk          (clk),
      .reset        (reset),
      .i_src_beat   (i_src_beat),
      .i_src_valid  (i_src_valid),
      .o_src_ready  (o_src_ready),
      .i_resp_beat  (resp_beat),
      .i_resp_valid (resp_valid),
      .o_resp_ready (resp_ready),
      .o_out_beat   (o_out_beat),
      .o_out_valid  (o_out_valid),
      .i_out_ready  (i_out_ready)
   );

endmodule

`default_nettype wire

//--- verification/noc_shell_tb.sv
// Directed testbench for the single-port NoC shell
// Clock and reset, input and stream source packet drivers
// Output, sink and settings bus collectors
// Readback model for the expected response payloads

`default_nettype none

module noc_shell_tb;

   localparam noc_shell_pkg::rb_data_t TB_NOC_ID = 64'hDEAD_BEEF_0123_4567;
   localparam noc_shell_pkg::rb_data_t USER_RB   = 64'hFEED_FACE_CAFE_0042;
   localparam int                      TIMEOUT   = 2000;

   logic                      clk;
   logic                      reset;
   noc_shell_pkg::chdr_beat_t in_beat;
   logic                      in_valid;
   logic                      in_ready;
   noc_shell_pkg::chdr_beat_t out_beat;
   logic                      out_valid;
   logic                      out_ready;
   noc_shell_pkg::chdr_beat_t sink_beat;
   logic                      sink_valid;
   logic                      sink_ready;
   noc_shell_pkg::chdr_beat_t src_beat;
   logic                      src_valid;
   logic                      src_ready;
   logic                      set_stb;
   noc_shell_pkg::set_addr_t  set_addr;
   noc_shell_pkg::set_data_t  set_data;
   logic                      rb_stb;
   noc_shell_pkg::rb_data_t   rb_data;
   noc_shell_pkg::sid_t       src_sid;
   noc_shell_pkg::sid_t       next_dst_sid;

   // Collected and expected beats
   noc_shell_pkg::chdr_beat_t sink_q[$];
   noc_shell_pkg::chdr_beat_t sink_exp_q[$];
   noc_shell_pkg::chdr_beat_t src_q[$];
   noc_shell_pkg::chdr_beat_t src_exp_q[$];
   noc_shell_pkg::chdr_beat_t resp_q[$];
   logic [39:0]               set_q[$];

   logic                      out_first;
   logic                      out_is_resp;
   logic                      rand_sink;
   logic                      rand_out;
   int                        mismatches;
   int                        other_errors;

   // Shell register model
   noc_shell_pkg::rb_sel_t    model_sel;
   noc_shell_pkg::sid_t       model_src_sid;
   noc_shell_pkg::sid_t       model_next_sid;
   noc_shell_pkg::seqnum_t    next_seq;

   noc_shell_top #(
      .NOC_ID (TB_NOC_ID)
   ) UUT (
      .clk            (clk),
      .reset          (reset),
      .i_in_beat      (in_beat),
      .i_in_valid     (in_valid),
      .o_in_ready     (in_ready),
      .o_out_beat     (out_beat),
      .o_out_valid    (out_valid),
      .i_out_ready    (out_ready),
      .o_sink_beat    (sink_beat),
      .o_sink_valid   (sink_valid),
      .i_sink_ready   (sink_ready),
      .i_src_beat     (src_beat),
      .i_src_valid    (src_valid),
      .o_src_ready    (src_ready),
      .o_set_stb      (set_stb),
      .o_set_addr     (set_addr),
      .o_set_data     (set_data),
      .i_rb_stb       (rb_stb),
      .i_rb_data      (rb_data),
      .o_src_sid      (src_sid),
      .o_next_dst_sid (next_dst_sid)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Ready patterns change on the falling edge
   initial begin
      sink_ready = 1'b1;
      out_ready  = 1'b1;
      forever begin
         @(negedge clk);
         sink_ready = rand_sink ? ($urandom % 4 != 0) : 1'b1;
         out_ready  = rand_out ? ($urandom % 3 != 0) : 1'b1;
      end
   end

   ////////////////////////////////////////
   // Collectors
   ////////////////////////////////////////

   // Output packets split by header type into responses and source packets
   always @(posedge clk) begin
      if (reset) begin
         out_first   = 1'b1;
         out_is_resp = 1'b0;
      end else begin
         if (sink_valid && sink_ready) sink_q.push_back(sink_beat);
         if (set_stb) set_q.push_back({set_addr, set_data});
         if (out_valid && out_ready) begin
            if (out_first) begin
               out_is_resp = ({out_beat.tdata[63:62], out_beat.tdata[60]} == noc_shell_pkg::RESP);
            end
            if (out_is_resp) resp_q.push_back(out_beat);
            else src_q.push_back(out_beat);
            out_first = out_beat.tlast;
         end
      end
   end

   ////////////////////////////////////////
   // Reporting and models
   ////////////////////////////////////////

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      mismatches++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
   endtask

   task automatic report_error(input string what);
      other_errors++;
      $display("%s", what);
   endtask

   task automatic timeout_abort(input string what);
      $display("Timeout while waiting for %s", what);
      $display("Mismatches: %0d, other errors: %0d", mismatches, other_errors);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   task automatic compare_beat(input string name, input noc_shell_pkg::chdr_beat_t got,
                               input noc_shell_pkg::chdr_beat_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch %s: got tlast 0x%0h tdata 0x%h, expected tlast 0x%0h tdata 0x%h",
                  name, got.tlast, got.tdata, exp.tlast, exp.tdata);
      end
   endtask

   // Type bits sit at 63, 62 and 60 with bit 61 clear
   function automatic logic [63:0] make_header(input noc_shell_pkg::pkt_type_e t,
                                               input noc_shell_pkg::seqnum_t seq,
                                               input noc_shell_pkg::pkt_len_t len,
                                               input noc_shell_pkg::sid_t src,
                                               input noc_shell_pkg::sid_t dst);
      logic [2:0] tbits;
      tbits = t;
      return {tbits[2:1], 1'b0, tbits[0], seq, len, src, dst};
   endfunction

   function automatic noc_shell_pkg::rb_data_t model_readback();
      case (model_sel)
         noc_shell_pkg::RB_NOC_ID:          return TB_NOC_ID;
         noc_shell_pkg::RB_BLOCK_PORT_SIDS: return {model_src_sid, model_next_sid, 32'd0};
         noc_shell_pkg::RB_USER_RB_DATA:    return USER_RB;
         noc_shell_pkg::RB_COMPAT_NUM:      return {32'd4, 32'd0};
         default:                           return 64'h0BAD_C0DE_0BAD_C0DE;
      endcase
   endfunction

   ////////////////////////////////////////
   // Drivers
   ////////////////////////////////////////

   task automatic drive_in_beat(input noc_shell_pkg::chdr_beat_t beat, output int stalls);
      int waited;
      waited = 0;
      @(negedge clk);
      in_beat  = beat;
      in_valid = 1'b1;
      @(posedge clk);
      while (!in_ready) begin
         waited++;
         if (waited > TIMEOUT) timeout_abort("o_in_ready");
         @(posedge clk);
      end
      stalls = waited;
   endtask

   task automatic drive_src_beat(input noc_shell_pkg::chdr_beat_t beat);
      int waited;
      waited = 0;
      @(negedge clk);
      src_beat  = beat;
      src_valid = 1'b1;
      @(posedge clk);
      while (!src_ready) begin
         waited++;
         if (waited > TIMEOUT) timeout_abort("o_src_ready");
         @(posedge clk);
      end
   endtask

   // Data types land on the sink and the rest here are dropped
   task automatic send_packet(input noc_shell_pkg::pkt_type_e t, input int n_payload);
      noc_shell_pkg::chdr_beat_t beat;
      noc_shell_pkg::pkt_len_t   len;
      logic                      to_sink;
      int                        stalls;
      int                        i;
      len     = noc_shell_pkg::pkt_len_t'(8 * (n_payload + 1));
      to_sink = (t == noc_shell_pkg::DATA) || (t == noc_shell_pkg::DATA_EOB) ||
                (t == noc_shell_pkg::FC_ACK);
      for (i = 0; i <= n_payload; i++) begin
         beat.tlast = (i == n_payload);
         if (i == 0) begin
            beat.tdata = make_header(t, noc_shell_pkg::seqnum_t'($urandom), len,
                                     noc_shell_pkg::sid_t'($urandom),
                                     noc_shell_pkg::sid_t'($urandom));
         end else begin
            beat.tdata = {$urandom, $urandom};
         end
         drive_in_beat(beat, stalls);
         if (to_sink) sink_exp_q.push_back(beat);
         if (!to_sink && stalls != 0) report_error("o_in_ready low during a discarded packet");
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic send_source_packet(input int n_payload);
      noc_shell_pkg::chdr_beat_t beat;
      int                        i;
      for (i = 0; i <= n_payload; i++) begin
         beat.tlast = (i == n_payload);
         if (i == 0) begin
            beat.tdata = make_header(noc_shell_pkg::DATA, noc_shell_pkg::seqnum_t'(i),
                                     noc_shell_pkg::pkt_len_t'(8 * (n_payload + 1)),
                                     16'h0040, noc_shell_pkg::sid_t'($urandom));
         end else begin
            beat.tdata = {$urandom, $urandom};
         end
         src_exp_q.push_back(beat);
         drive_src_beat(beat);
      end
      @(negedge clk);
      src_valid = 1'b0;
   endtask

   // Sends one command, then checks the write and the two-beat response
   task automatic send_command(input noc_shell_pkg::set_addr_t addr,
                               input noc_shell_pkg::set_data_t data);
      noc_shell_pkg::chdr_beat_t beat;
      noc_shell_pkg::chdr_beat_t exp;
      noc_shell_pkg::sid_t       src;
      noc_shell_pkg::sid_t       dst;
      noc_shell_pkg::seqnum_t    seq;
      logic [39:0]               set_word;
      int                        stalls;
      int                        waited;
      src      = noc_shell_pkg::sid_t'($urandom);
      dst      = noc_shell_pkg::sid_t'($urandom);
      seq      = next_seq;
      next_seq = next_seq + 12'd1;
      beat.tlast = 1'b0;
      beat.tdata = make_header(noc_shell_pkg::CMD, seq, 16'd16, src, dst);
      drive_in_beat(beat, stalls);
      beat.tlast = 1'b1;
      beat.tdata = {24'd0, addr, data};
      drive_in_beat(beat, stalls);
      @(negedge clk);
      in_valid = 1'b0;
      case (addr)
         noc_shell_pkg::SR_RB_ADDR:      model_sel      = data[2:0];
         noc_shell_pkg::SR_SRC_SID:      model_src_sid  = data[15:0];
         noc_shell_pkg::SR_NEXT_DST_SID: model_next_sid = data[15:0];
         default: ;
      endcase
      waited = 0;
      while (resp_q.size() < 2) begin
         waited++;
         if (waited > TIMEOUT) timeout_abort("a command response");
         @(negedge clk);
      end
      if (set_q.size() != 1) begin
         report_error($sformatf("expected one settings strobe, saw %0d", set_q.size()));
      end
      if (set_q.size() != 0) begin
         set_word = set_q.pop_front();
         if (set_word[39:32] !== addr) report_mismatch("o_set_addr", 64'(set_word[39:32]),
                                                       64'(addr));
         if (set_word[31:0] !== data) report_mismatch("o_set_data", 64'(set_word[31:0]),
                                                      64'(data));
      end
      set_q.delete();
      // Response goes back to the sender with the SIDs swapped
      exp.tlast = 1'b0;
      exp.tdata = make_header(noc_shell_pkg::RESP, seq, 16'd16, dst, src);
      compare_beat("o_out_beat response header", resp_q.pop_front(), exp);
      exp.tlast = 1'b1;
      exp.tdata = model_readback();
      compare_beat("o_out_beat response payload", resp_q.pop_front(), exp);
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////

   task automatic check_readback_sources();
      if (out_valid !== 1'b0) report_error("o_out_valid is not low after reset");
      if (sink_valid !== 1'b0) report_error("o_sink_valid is not low after reset");
      if (set_stb !== 1'b0) report_error("o_set_stb is not low after reset");
      send_command(noc_shell_pkg::SR_RB_ADDR, 32'(noc_shell_pkg::RB_NOC_ID));
      send_command(noc_shell_pkg::SR_RB_ADDR, 32'(noc_shell_pkg::RB_COMPAT_NUM));
      send_command(noc_shell_pkg::SR_RB_ADDR, 32'd3);
   endtask

   task automatic route_stream_packets();
      int waited;
      rand_sink = 1'b1;
      send_packet(noc_shell_pkg::DATA, 3);
      send_packet(noc_shell_pkg::FC_RESP, 1);
      send_packet(noc_shell_pkg::DATA_EOB, 2);
      send_packet(noc_shell_pkg::RESP, 1);
      send_packet(noc_shell_pkg::FC_ACK, 1);
      send_packet(noc_shell_pkg::DATA, 4);
      waited = 0;
      while (sink_q.size() < sink_exp_q.size()) begin
         waited++;
         if (waited > TIMEOUT) timeout_abort("stream sink beats");
         @(negedge clk);
      end
      while (sink_exp_q.size() != 0) begin
         compare_beat("o_sink_beat", sink_q.pop_front(), sink_exp_q.pop_front());
      end
      if (sink_q.size() != 0) report_error("extra beats on the stream sink");
      if (resp_q.size() != 0 || src_q.size() != 0) report_error("dropped packet on output");
      if (set_q.size() != 0) report_error("settings strobe without a command");
      rand_sink = 1'b0;
   endtask

   task automatic write_user_setting();
      send_command(noc_shell_pkg::SR_RB_ADDR, 32'(noc_shell_pkg::RB_USER_RB_DATA));
      send_command(8'h10, $urandom);
      send_command(8'h7F, $urandom);
   endtask

   task automatic update_stream_ids();
      noc_shell_pkg::sid_t sid_a;
      noc_shell_pkg::sid_t sid_b;
      sid_a = noc_shell_pkg::sid_t'($urandom);
      sid_b = noc_shell_pkg::sid_t'($urandom);
      send_command(noc_shell_pkg::SR_SRC_SID, {16'hA5A5, sid_a});
      if (src_sid !== sid_a) report_mismatch("o_src_sid", 64'(src_sid), 64'(sid_a));
      send_command(noc_shell_pkg::SR_NEXT_DST_SID, {16'h5A5A, sid_b});
      if (next_dst_sid !== sid_b) begin
         report_mismatch("o_next_dst_sid", 64'(next_dst_sid), 64'(sid_b));
      end
      send_command(noc_shell_pkg::SR_RB_ADDR, 32'(noc_shell_pkg::RB_BLOCK_PORT_SIDS));
   endtask

   task automatic merge_output_streams();
      int waited;
      rand_out = 1'b1;
      fork
         begin
            repeat (4) send_source_packet(1 + int'($urandom % 4));
         end
         begin
            send_command(noc_shell_pkg::SR_RB_ADDR, 32'(noc_shell_pkg::RB_COMPAT_NUM));
            send_command(8'h20, $urandom);
            send_command(noc_shell_pkg::SR_RB_ADDR, 32'(noc_shell_pkg::RB_NOC_ID));
         end
      join
      waited = 0;
      while (src_q.size() < src_exp_q.size()) begin
         waited++;
         if (waited > TIMEOUT) timeout_abort("stream source beats on the output");
         @(negedge clk);
      end
      while (src_exp_q.size() != 0) begin
         compare_beat("o_out_beat", src_q.pop_front(), src_exp_q.pop_front());
      end
      if (src_q.size() != 0) report_error("extra source beats on the output");
      if (resp_q.size() != 0) report_error("extra response beats on the output");
      rand_out = 1'b0;
   endtask

   initial begin
      void'($urandom(33939));
      reset          = 1'b1;
      in_beat        = '0;
      in_valid       = 1'b0;
      src_beat       = '0;
      src_valid      = 1'b0;
      rb_stb         = 1'b1;
      rb_data        = USER_RB;
      rand_sink      = 1'b0;
      rand_out       = 1'b0;
      mismatches     = 0;
      other_errors   = 0;
      model_sel      = noc_shell_pkg::RB_NOC_ID;
      model_src_sid  = '0;
      model_next_sid = '0;
      next_seq       = 12'h100;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check_readback_sources();
      route_stream_packets();
      write_user_setting();
      update_stream_ids();
      merge_output_streams();
      $display("Mismatches: %0d, other errors: %0d", mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
rtl/noc_shell_pkg.sv
rtl/pkt_type_router.sv
rtl/cmd_pkt_proc.sv
rtl/shell_regs.sv
rtl/output_arbiter.sv
rtl/noc_shell_top.sv
verification/noc_shell_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the NoC shell testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module noc_shell_tb -Mdir obj_dir -o noc_shell_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/noc_shell_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
